//--- Makefile
TOP := spi_slave_tb
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ns --top-module $(TOP) -Mdir $(OBJ) -f project.f

run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	@if grep -q "Simulation failed" sim.log; then echo "Run reported a failure"; exit 1; fi
	@grep -q "Simulation passed" sim.log || (echo "Run ended without a result"; exit 1)

clean:
	rm -rf $(OBJ) sim.log

//--- hw/spi_cfg_if.sv
//////////////////////////////
// Active SPI mode and frame length, driven by the register block
// and read by every channel. The length is already clamped here
//////////////////////////////

`timescale 1ns/1ns

interface spi_cfg_if;
    import spi_frame_pkg::*;

    logic       clock_polarity;
    logic       latching_edge;
    logic       ss_polarity;
    logic       msb_first;
    frame_len_t transfer_length;

    modport regs (
        output clock_polarity,
        output latching_edge,
        output ss_polarity,
        output msb_first,
        output transfer_length
    );

    modport channel (
        input clock_polarity,
        input latching_edge,
        input ss_polarity,
        input msb_first,
        input transfer_length
    );

endinterface

//--- hw/spi_cfg_pkg.sv
//////////////////////////////
// Register map of the SPI slave port. Addresses are word indexes
// on a 2 bit register port. The status word holds a 16 bit frame count
// and up to 16 overrun flags, one per channel, from bit 16 upwards
//////////////////////////////

package spi_cfg_pkg;

    typedef logic [1:0]  cfg_addr_t;
    typedef logic [31:0] cfg_data_t;

    localparam cfg_addr_t CFG_CTRL_ADDR   = 2'd0;
    localparam cfg_addr_t CFG_LEN_ADDR    = 2'd1;
    // The status register is read only and any write clears count and flags
    localparam cfg_addr_t CFG_STATUS_ADDR = 2'd2;

    // Control register fields
    localparam int CTRL_CPOL_BIT  = 0;
    localparam int CTRL_EDGE_BIT  = 1;
    localparam int CTRL_SSPOL_BIT = 2;
    localparam int CTRL_MSB_BIT   = 3;
    localparam int CTRL_WIDTH     = 4;

    // Status register layout
    localparam int STATUS_COUNT_BITS = 16;
    localparam int STATUS_FLAG_LSB   = 16;

    typedef logic [STATUS_COUNT_BITS-1:0] frame_count_t;

endpackage

//--- hw/spi_config_regs.sv
//////////////////////////////
// Control, length and status registers. Lengths of 0 or above
// REGISTERS_WIDTH read back and act as REGISTERS_WIDTH.
// N_CHANNELS must not exceed 16 for the status flags to fit
//////////////////////////////

`timescale 1ns/1ns

module spi_config_regs #(
    parameter int N_CHANNELS      = 3,
    parameter int REGISTERS_WIDTH = 16
) (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  cfg_we,
    input  spi_cfg_pkg::cfg_addr_t cfg_addr,
    input  spi_cfg_pkg::cfg_data_t cfg_wdata,
    output spi_cfg_pkg::cfg_data_t cfg_rdata,
    input  logic [N_CHANNELS-1:0] frame_done,
    input  logic [N_CHANNELS-1:0] overrun,
    spi_cfg_if.regs               cfg
);
    import spi_cfg_pkg::*;
    import spi_frame_pkg::*;

    localparam frame_len_t FULL_LEN = frame_len_t'(REGISTERS_WIDTH);
    localparam int DONE_W = $clog2(N_CHANNELS + 1);

    logic [CTRL_WIDTH-1:0] ctrl_reg;
    // Zero stands for the full word length, which is also the reset state
    frame_len_t            len_reg;
    frame_len_t            active_len;
    logic                  len_in_range;
    frame_count_t          frame_count;
    logic [N_CHANNELS-1:0] overrun_flags;
    logic [DONE_W-1:0]     done_count;
    cfg_data_t             status_word;

    assign len_in_range = (cfg_wdata != '0) && (cfg_wdata <= cfg_data_t'(REGISTERS_WIDTH));
    assign active_len   = (len_reg == '0) ? FULL_LEN : len_reg;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ctrl_reg <= '0;
            len_reg  <= '0;
        end else if (cfg_we) begin
            case (cfg_addr)
                CFG_CTRL_ADDR: ctrl_reg <= cfg_wdata[CTRL_WIDTH-1:0];
                CFG_LEN_ADDR:  len_reg  <= len_in_range ? frame_len_t'(cfg_wdata) : '0;
                default: ;
            endcase
        end
    end

    // Several channels may finish a frame in the same cycle
    always_comb begin
        done_count = '0;
        for (int i = 0; i < N_CHANNELS; i++) begin
            done_count = done_count + DONE_W'(frame_done[i]);
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            frame_count   <= '0;
            overrun_flags <= '0;
        end else if (cfg_we && cfg_addr == CFG_STATUS_ADDR) begin
            frame_count   <= '0;
            overrun_flags <= '0;
        end else begin
            frame_count   <= frame_count + frame_count_t'(done_count);
            overrun_flags <= overrun_flags | overrun;
        end
    end

    always_comb begin
        status_word = '0;
        status_word[STATUS_COUNT_BITS-1:0] = frame_count;
        status_word[STATUS_FLAG_LSB +: N_CHANNELS] = overrun_flags;
    end

    always_comb begin
        case (cfg_addr)
            CFG_CTRL_ADDR:   cfg_rdata = cfg_data_t'(ctrl_reg);
            CFG_LEN_ADDR:    cfg_rdata = cfg_data_t'(active_len);
            CFG_STATUS_ADDR: cfg_rdata = status_word;
            default:         cfg_rdata = '0;
        endcase
    end

    assign cfg.clock_polarity  = ctrl_reg[CTRL_CPOL_BIT];
    assign cfg.latching_edge   = ctrl_reg[CTRL_EDGE_BIT];
    assign cfg.ss_polarity     = ctrl_reg[CTRL_SSPOL_BIT];
    assign cfg.msb_first       = ctrl_reg[CTRL_MSB_BIT];
    assign cfg.transfer_length = active_len;

endmodule

//--- hw/spi_frame_pkg.sv
//////////////////////////////
// Frame geometry shared by the register block and the channels.
// Word widths above MAX_WORD_BITS are not supported
//////////////////////////////

package spi_frame_pkg;

    // Largest word a channel can shift in one frame
    localparam int MAX_WORD_BITS = 32;

    // A frame length in bits, wide enough to hold MAX_WORD_BITS itself
    typedef logic [$clog2(MAX_WORD_BITS+1)-1:0] frame_len_t;

    // Flip-flops between an SPI pin and the system clock domain
    localparam int SYNC_STAGES = 2;

endpackage

//--- hw/spi_slave_channel.sv
//////////////////////////////
// One oversampled SPI slave. SCLK levels must last 4 clock cycles
// or more; pins are acted on 3 cycles after they change.
// REGISTERS_WIDTH must be at least 2
//////////////////////////////

`timescale 1ns/1ns

module spi_slave_channel #(
    parameter int REGISTERS_WIDTH = 16
) (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       enable,
    input  logic                       sclk,
    input  logic                       ss,
    input  logic                       mosi,
    output logic                       miso,
    spi_cfg_if.channel                 cfg,
    input  logic [REGISTERS_WIDTH-1:0] tx_data,
    input  logic                       tx_valid,
    output logic                       tx_ready,
    output logic [REGISTERS_WIDTH-1:0] rx_data,
    output logic                       rx_valid,
    input  logic                       rx_ready,
    output logic                       frame_done,
    output logic                       overrun
);
    import spi_frame_pkg::*;

    typedef enum logic [1:0] {IDLE, ACTIVE, DONE} chan_state_t;
    typedef logic [REGISTERS_WIDTH-1:0] word_t;

    chan_state_t            state;
    logic [SYNC_STAGES-1:0] sclk_sync;
    logic [SYNC_STAGES-1:0] ss_sync;
    logic [SYNC_STAGES-1:0] mosi_sync;
    logic                   sclk_prev;
    logic                   ss_prev;
    logic                   sclk_s;
    logic                   ss_s;
    logic                   mosi_s;
    logic                   lead_edge;
    logic                   trail_edge;
    logic                   latch_edge;
    logic                   shift_edge;
    logic                   sel_now;
    logic                   sel_prev;
    logic                   sel_start;
    logic                   load;
    logic                   last_bit;
    logic                   complete;
    logic                   rx_blocked;
    frame_len_t             bit_count;
    int                     pad_bits;
    word_t                  tx_shift;
    word_t                  tx_load;
    word_t                  rx_shift;
    word_t                  rx_next;
    word_t                  rx_word;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            sclk_sync <= '0;
            ss_sync   <= '0;
            mosi_sync <= '0;
            sclk_prev <= 1'b0;
            ss_prev   <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[SYNC_STAGES-2:0], sclk};
            ss_sync   <= {ss_sync[SYNC_STAGES-2:0], ss};
            mosi_sync <= {mosi_sync[SYNC_STAGES-2:0], mosi};
            sclk_prev <= sclk_s;
            ss_prev   <= ss_s;
        end
    end

    assign sclk_s = sclk_sync[SYNC_STAGES-1];
    assign ss_s   = ss_sync[SYNC_STAGES-1];
    assign mosi_s = mosi_sync[SYNC_STAGES-1];

    // With CPOL set the idle level is high, so the leading edge is a fall
    assign lead_edge  = cfg.clock_polarity ? (~sclk_s & sclk_prev) : (sclk_s & ~sclk_prev);
    assign trail_edge = cfg.clock_polarity ? (sclk_s & ~sclk_prev) : (~sclk_s & sclk_prev);
    assign latch_edge = cfg.latching_edge ? trail_edge : lead_edge;
    assign shift_edge = cfg.latching_edge ? lead_edge : trail_edge;

    // Both samples use the current polarity, so a polarity write alone starts no frame
    assign sel_now   = (ss_s == cfg.ss_polarity);
    assign sel_prev  = (ss_prev == cfg.ss_polarity);
    assign sel_start = enable & sel_now & ~sel_prev;

    assign load       = (state == IDLE) & sel_start;
    assign last_bit   = (frame_len_t'(bit_count + 1'b1) == cfg.transfer_length);
    assign complete   = (state == ACTIVE) & enable & sel_now & latch_edge & last_bit;
    assign rx_blocked = rx_valid & ~rx_ready;
    assign tx_ready   = load & tx_valid;

    // Short frames use the low bits; MSB first needs them moved to the top of the shifter
    assign pad_bits = REGISTERS_WIDTH - int'(cfg.transfer_length);
    assign tx_load  = !tx_valid ? '0 : (cfg.msb_first ? (tx_data << pad_bits) : tx_data);
    assign rx_next  = cfg.msb_first ? {rx_shift[REGISTERS_WIDTH-2:0], mosi_s}
                                    : {mosi_s, rx_shift[REGISTERS_WIDTH-1:1]};
    assign rx_word  = cfg.msb_first ? rx_next : (rx_next >> pad_bits);

    assign miso = enable & (state == ACTIVE) &
                  (cfg.msb_first ? tx_shift[REGISTERS_WIDTH-1] : tx_shift[0]);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state      <= IDLE;
            bit_count  <= '0;
            rx_valid   <= 1'b0;
            frame_done <= 1'b0;
            overrun    <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            overrun    <= 1'b0;
            if (rx_valid && rx_ready) begin
                rx_valid <= 1'b0;
            end
            if (complete) begin
                if (rx_blocked) begin
                    overrun <= 1'b1;
                end else begin
                    rx_valid   <= 1'b1;
                    frame_done <= 1'b1;
                end
            end
            if (!enable) begin
                state <= IDLE;
            end else begin
                case (state)
                    IDLE: begin
                        if (sel_start) begin
                            state     <= ACTIVE;
                            bit_count <= '0;
                        end
                    end
                    ACTIVE: begin
                        // Losing select here drops the partial word
                        if (!sel_now) begin
                            state <= IDLE;
                        end else if (latch_edge) begin
                            bit_count <= frame_len_t'(bit_count + 1'b1);
                            if (last_bit) begin
                                state <= DONE;
                            end
                        end
                    end
                    DONE: begin
                        if (!sel_now) begin
                            state <= IDLE;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            tx_shift <= tx_load;
            rx_shift <= '0;
        end else if (state == ACTIVE) begin
            if (latch_edge) begin
                rx_shift <= rx_next;
            end
            // No shift before the first bit is latched, which keeps bit one for trailing-edge modes
            if (shift_edge && bit_count != '0) begin
                tx_shift <= cfg.msb_first ? (tx_shift << 1) : (tx_shift >> 1);
            end
        end
        if (complete && !rx_blocked) begin
            rx_data <= rx_word;
        end
    end

endmodule

//--- hw/spi_slave_top.sv
//////////////////////////////
// SPI slave port with N_CHANNELS channels on one shared SCLK.
// Stream buses are packed, channel 0 in the low bits.
// Adds no latency to the channels
//////////////////////////////

`timescale 1ns/1ns

module spi_slave_top #(
    parameter int N_CHANNELS      = 3,
    parameter int REGISTERS_WIDTH = 16
) (
    input  logic                                       clock,
    input  logic                                       rst_n,
    input  logic                                       enable,
    input  logic                                       sclk,
    input  logic [N_CHANNELS-1:0]                      ss,
    input  logic [N_CHANNELS-1:0]                      mosi,
    output logic [N_CHANNELS-1:0]                      miso,
    input  logic                                       cfg_we,
    input  spi_cfg_pkg::cfg_addr_t                     cfg_addr,
    input  spi_cfg_pkg::cfg_data_t                     cfg_wdata,
    output spi_cfg_pkg::cfg_data_t                     cfg_rdata,
    input  logic [N_CHANNELS-1:0][REGISTERS_WIDTH-1:0] tx_data,
    input  logic [N_CHANNELS-1:0]                      tx_valid,
    output logic [N_CHANNELS-1:0]                      tx_ready,
    output logic [N_CHANNELS-1:0][REGISTERS_WIDTH-1:0] rx_data,
    output logic [N_CHANNELS-1:0]                      rx_valid,
    input  logic [N_CHANNELS-1:0]                      rx_ready
);

    logic [N_CHANNELS-1:0] frame_done;
    logic [N_CHANNELS-1:0] overrun;

    spi_cfg_if cfg_bus ();

    spi_config_regs #(
        .N_CHANNELS      (N_CHANNELS),
        .REGISTERS_WIDTH (REGISTERS_WIDTH)
    ) u_regs (
        .clock      (clock),
        .rst_n      (rst_n),
        .cfg_we     (cfg_we),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata),
        .frame_done (frame_done),
        .overrun    (overrun),
        .cfg        (cfg_bus.regs)
    );

    // All channels share SCLK and the mode, each has its own select and data pins
    for (genvar i = 0; i < N_CHANNELS; i++) begin : gen_channel
        spi_slave_channel #(
            .REGISTERS_WIDTH (REGISTERS_WIDTH)
        ) u_channel (
            .clock      (clock),
            .rst_n      (rst_n),
            .enable     (enable),
            .sclk       (sclk),
            .ss         (ss[i]),
            .mosi       (mosi[i]),
            .miso       (miso[i]),
            .cfg        (cfg_bus.channel),
            .tx_data    (tx_data[i]),
            .tx_valid   (tx_valid[i]),
            .tx_ready   (tx_ready[i]),
            .rx_data    (rx_data[i]),
            .rx_valid   (rx_valid[i]),
            .rx_ready   (rx_ready[i]),
            .frame_done (frame_done[i]),
            .overrun    (overrun[i])
        );
    end

endmodule

//--- project.f
hw/spi_cfg_pkg.sv
hw/spi_frame_pkg.sv
hw/spi_cfg_if.sv
hw/spi_config_regs.sv
hw/spi_slave_channel.sv
hw/spi_slave_top.sv
test/tb_clock_gen.sv
test/spi_slave_tb.sv

//--- test/spi_slave_tb.sv
//////////////////////////////
// Table driven testbench for the SPI slave port, 3 channels of 16 bits.
// The SPI master uses 6 cycle half periods and drives all channels
// at once with one mode and length per test
//////////////////////////////

`timescale 1ns/1ns

module spi_slave_tb;
    import spi_cfg_pkg::*;

    localparam int N_CH    = 3;
    localparam int W       = 16;
    localparam int HALF    = 6;
    localparam int RX_WAIT = 50;

    typedef logic [N_CH-1:0][W-1:0] word_array_t;

    typedef struct {
        string           name;
        logic [3:0]      ctrl;
        int              len_wr;
        int              len_exp;
        int              holdoff;
        logic            enable;
        logic [N_CH-1:0] tx_valid;
        logic            ss_active;
        int              abort_at;
        logic [N_CH-1:0] repeat_mask;
        word_array_t     mosi_w;
        word_array_t     tx_w;
    } test_t;

    logic            clock;
    logic            rst_n;
    logic            enable;
    logic            sclk;
    logic [N_CH-1:0] ss;
    logic [N_CH-1:0] mosi;
    logic [N_CH-1:0] miso;
    logic            cfg_we;
    cfg_addr_t       cfg_addr;
    cfg_data_t       cfg_wdata;
    cfg_data_t       cfg_rdata;
    word_array_t     tx_data;
    logic [N_CH-1:0] tx_valid;
    logic [N_CH-1:0] tx_ready;
    word_array_t     rx_data;
    logic [N_CH-1:0] rx_valid;
    logic [N_CH-1:0] rx_ready;

    test_t tests[$];
    int    errors = 0;
    int    checks = 0;
    int    cycles = 0;
    int    cycle_limit = 0;
    int    hs_total = 0;
    int    tx_hs_total = 0;

    tb_clock_gen #(.PERIOD_NS(10)) u_clock (.clock(clock));

    spi_slave_top #(
        .N_CHANNELS      (N_CH),
        .REGISTERS_WIDTH (W)
    ) DUT (
        .clock     (clock),
        .rst_n     (rst_n),
        .enable    (enable),
        .sclk      (sclk),
        .ss        (ss),
        .mosi      (mosi),
        .miso      (miso),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready)
    );

    // Counts the words that pass on the receive and the transmit stream
    always @(negedge clock) begin
        hs_total    <= hs_total + $countones(rx_valid & rx_ready);
        tx_hs_total <= tx_hs_total + $countones(tx_valid & tx_ready);
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s %s: expected %h, actual %h", test, what, expected, actual);
        end
    endtask

    function automatic logic [31:0] low_bits(input logic [31:0] value, input int len);
        return value & ((32'h1 << len) - 32'h1);
    endfunction

    // Lengths of 0 or above the word width act as the full width
    task automatic add_test(input string name, input logic [3:0] ctrl, input int len,
                            input int holdoff, input logic en, input logic [N_CH-1:0] txv,
                            input logic ss_act, input int abort_at,
                            input logic [N_CH-1:0] repeat_mask);
        test_t t;
        t.name        = name;
        t.ctrl        = ctrl;
        t.len_wr      = len;
        t.len_exp     = (len == 0 || len > W) ? W : len;
        t.holdoff     = holdoff;
        t.enable      = en;
        t.tx_valid    = txv;
        t.ss_active   = ss_act;
        t.abort_at    = abort_at;
        t.repeat_mask = repeat_mask;
        for (int c = 0; c < N_CH; c++) begin
            t.mosi_w[c] = W'($urandom);
            t.tx_w[c]   = W'($urandom);
        end
        tests.push_back(t);
    endtask

    task automatic write_reg(input cfg_addr_t addr, input cfg_data_t data);
        @(posedge clock);
        cfg_we    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clock);
        cfg_we    <= 1'b0;
    endtask

    task automatic read_reg(input cfg_addr_t addr, output cfg_data_t data);
        @(posedge clock);
        cfg_addr <= addr;
        @(negedge clock);
        data = cfg_rdata;
    endtask

    // Returns on a rising edge with miso as it stood half a cycle before
    task automatic wait_half(output logic [N_CH-1:0] seen);
        repeat (HALF - 1) @(posedge clock);
        @(negedge clock);
        seen = miso;
        @(posedge clock);
    endtask

    // SPI master on the channels in chans, sending and capturing bits per the mode
    task automatic run_frame(input test_t t, input logic [N_CH-1:0] chans,
                             input word_array_t words, input int bits,
                             output word_array_t captured);
        logic [N_CH-1:0] col;
        logic [N_CH-1:0] seen;
        logic [N_CH-1:0] got;
        logic            cpol;
        logic            trail;
        logic            msb;
        logic            act;
        int              pos;
        cpol     = t.ctrl[CTRL_CPOL_BIT];
        trail    = t.ctrl[CTRL_EDGE_BIT];
        msb      = t.ctrl[CTRL_MSB_BIT];
        act      = t.ctrl[CTRL_SSPOL_BIT];
        captured = '0;
        @(posedge clock);
        if (t.ss_active) begin
            ss <= act ? chans : ~chans;
        end
        repeat (HALF) @(posedge clock);
        for (int b = 0; b < bits; b++) begin
            pos = msb ? (t.len_exp - 1 - b) : b;
            for (int c = 0; c < N_CH; c++) begin
                col[c] = words[c][pos];
            end
            if (!trail) begin
                mosi <= col;
            end
            wait_half(seen);
            got = seen;
            sclk <= ~cpol;
            if (trail) begin
                mosi <= col;
            end
            wait_half(seen);
            if (trail) begin
                got = seen;
            end
            sclk <= cpol;
            for (int c = 0; c < N_CH; c++) begin
                captured[c][pos] = got[c];
            end
        end
        repeat (HALF) @(posedge clock);
        ss <= {N_CH{~act}};
        repeat (HALF) @(posedge clock);
    endtask

    task automatic collect_rx(input test_t t);
        logic all_valid;
        all_valid = 1'b0;
        repeat (t.holdoff) @(posedge clock);
        for (int i = 0; i < RX_WAIT && !all_valid; i++) begin
            @(negedge clock);
            all_valid = (rx_valid == '1);
        end
        if (!all_valid) begin
            errors++;
            $display("Test %s: rx_valid did not rise on every channel in time", t.name);
        end
        for (int c = 0; c < N_CH; c++) begin
            check_value(t.name, "rx_data", low_bits(32'(t.mosi_w[c]), t.len_exp),
                        32'(rx_data[c]));
        end
        @(posedge clock);
        rx_ready <= '1;
        @(posedge clock);
        rx_ready <= '0;
        @(negedge clock);
        check_value(t.name, "rx_valid after handshake", 32'h0, 32'(rx_valid));
    endtask

    task automatic apply_test(input test_t t);
        word_array_t miso_got;
        cfg_data_t   rd;
        logic        expect_frame;
        logic        expect_load;
        logic [31:0] exp_miso;
        int          hs_start;
        int          tx_hs_start;
        expect_frame = t.ss_active && t.enable && (t.abort_at == 0);
        expect_load  = t.ss_active && t.enable;
        write_reg(CFG_CTRL_ADDR, cfg_data_t'(t.ctrl));
        write_reg(CFG_LEN_ADDR, cfg_data_t'(t.len_wr));
        write_reg(CFG_STATUS_ADDR, '0);
        read_reg(CFG_LEN_ADDR, rd);
        check_value(t.name, "length readback", 32'(t.len_exp), rd);
        // Pins move to the new idle levels only after the new mode is active
        @(posedge clock);
        sclk     <= t.ctrl[CTRL_CPOL_BIT];
        ss       <= {N_CH{~t.ctrl[CTRL_SSPOL_BIT]}};
        enable   <= t.enable;
        tx_data  <= t.tx_w;
        tx_valid <= t.tx_valid;
        hs_start    = hs_total;
        tx_hs_start = tx_hs_total;
        repeat (8) @(posedge clock);
        run_frame(t, '1, t.mosi_w, (t.abort_at != 0) ? t.abort_at : t.len_exp, miso_got);
        tx_valid <= '0;
        if (t.abort_at == 0) begin
            for (int c = 0; c < N_CH; c++) begin
                exp_miso = (expect_frame && t.tx_valid[c]) ?
                           low_bits(32'(t.tx_w[c]), t.len_exp) : 32'h0;
                check_value(t.name, "miso word", exp_miso, 32'(miso_got[c]));
            end
        end
        if (t.repeat_mask != '0) begin
            run_frame(t, t.repeat_mask, ~t.mosi_w, t.len_exp, miso_got);
        end
        if (expect_frame) begin
            read_reg(CFG_STATUS_ADDR, rd);
            check_value(t.name, "overrun flags", 32'(t.repeat_mask),
                        32'(rd[STATUS_FLAG_LSB +: N_CH]));
            check_value(t.name, "frame count", N_CH, 32'(rd[STATUS_COUNT_BITS-1:0]));
            if (t.repeat_mask != '0) begin
                write_reg(CFG_STATUS_ADDR, '0);
                read_reg(CFG_STATUS_ADDR, rd);
                check_value(t.name, "status after clear", 32'h0, rd);
            end
            collect_rx(t);
        end else begin
            repeat (2 * HALF) @(posedge clock);
            @(negedge clock);
            check_value(t.name, "rx_valid without frame", 32'h0, 32'(rx_valid));
        end
        read_reg(CFG_STATUS_ADDR, rd);
        check_value(t.name, "final frame count", (expect_frame && t.repeat_mask == '0) ? N_CH : 0,
                    32'(rd[STATUS_COUNT_BITS-1:0]));
        @(posedge clock);
        check_value(t.name, "handshakes", expect_frame ? N_CH : 0, 32'(hs_total - hs_start));
        // Each select assertion takes one word from every channel with tx_valid high
        check_value(t.name, "tx handshakes", expect_load ? $countones(t.tx_valid) : 0,
                    32'(tx_hs_total - tx_hs_start));
    endtask

    initial begin
        cfg_data_t rd;
        rst_n     = 1'b0;
        enable    = 1'b0;
        sclk      = 1'b0;
        ss        = '1;
        mosi      = '0;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        tx_data   = '0;
        tx_valid  = '0;
        rx_ready  = '0;
        void'($urandom(32'h9150_9f3e));

        // Control bits are msb_first, ss_polarity, latching_edge, clock_polarity
        add_test("mode0_msb_len8",     4'b1000,  8, 0, 1'b1, 3'b111, 1'b1,  0, 3'b000);
        add_test("mode1_lsb_len16",    4'b0010, 16, 1, 1'b1, 3'b111, 1'b1,  0, 3'b000);
        add_test("mode2_msb_len1",     4'b1001,  1, 0, 1'b1, 3'b111, 1'b1,  0, 3'b000);
        add_test("mode3_lsb_len8",     4'b0011,  8, 2, 1'b1, 3'b111, 1'b1,  0, 3'b000);
        add_test("mode3_msb_ss_high",  4'b1111, 16, 0, 1'b1, 3'b111, 1'b1,  0, 3'b000);
        add_test("mode1_lsb_len1",     4'b0110,  1, 0, 1'b1, 3'b111, 1'b1,  0, 3'b000);
        add_test("clamp_zero",         4'b1000,  0, 0, 1'b1, 3'b111, 1'b1,  0, 3'b000);
        add_test("clamp_forty",        4'b0010, 40, 0, 1'b1, 3'b111, 1'b1,  0, 3'b000);
        add_test("select_inactive",    4'b1100,  8, 0, 1'b1, 3'b111, 1'b0,  0, 3'b000);
        add_test("abort_after_5",      4'b1000, 16, 0, 1'b1, 3'b111, 1'b1,  5, 3'b000);
        add_test("abort_mode3",        4'b0011, 12, 0, 1'b1, 3'b111, 1'b1, 11, 3'b000);
        add_test("backpressure",       4'b1000,  8, 5, 1'b1, 3'b111, 1'b1,  0, 3'b010);
        add_test("tx_valid_low",       4'b1001, 12, 0, 1'b1, 3'b010, 1'b1,  0, 3'b000);
        add_test("enable_low",         4'b0000,  8, 0, 1'b0, 3'b111, 1'b1,  0, 3'b000);
        add_test("frame_count",        4'b0001,  4, 3, 1'b1, 3'b111, 1'b1,  0, 3'b000);
        cycle_limit = tests.size() * 40 * 12 + 2000;

        repeat (8) @(posedge clock);
        rst_n  <= 1'b1;
        enable <= 1'b1;
        @(negedge clock);
        check_value("reset", "rx_valid", 32'h0, 32'(rx_valid));
        check_value("reset", "tx_ready", 32'h0, 32'(tx_ready));
        check_value("reset", "miso", 32'h0, 32'(miso));
        read_reg(CFG_LEN_ADDR, rd);
        check_value("reset", "length", W, rd);

        foreach (tests[i]) begin
            apply_test(tests[i]);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- test/tb_clock_gen.sv
//////////////////////////////
// Free running clock for the testbench.
// The period must be an even number of ns
//////////////////////////////

`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS = 10
) (
    output logic clock
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

endmodule
